//--- Makefile
VERILATOR ?= verilator
TOP       ?= penalty_core_tb
FILELIST  ?= penalty_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(wildcard design/*.sv design/*.svh test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/game_state_sel.sv
`default_nettype none

`include "penalty_consts.svh"

module game_state_sel (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     left_clicked,
    input  logic                     right_clicked,
    input  logic                     solo_enable,
    input  logic                     connected,
    input  logic                     match_end,
    input  logic [`POS_W-1:0]        xpos,
    output penalty_pkg::g_state      game_state,
    output penalty_pkg::g_mode       game_mode,
    output logic                     shot_fire,
    output logic [`POS_W-1:0]        shot_xpos
);

    logic take_shot;

    assign take_shot = left_clicked && (game_state == penalty_pkg::ST_AIM);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            game_state <= penalty_pkg::ST_MENU;
            game_mode  <= penalty_pkg::MODE_SOLO;
            shot_fire  <= 1'b0;
        end else begin
            shot_fire <= take_shot;  // single cycle pulse
            case (game_state)
                penalty_pkg::ST_MENU: begin
                    if (left_clicked) begin
                        if (solo_enable) begin
                            game_mode  <= penalty_pkg::MODE_SOLO;
                            game_state <= penalty_pkg::ST_AIM;
                        end else if (connected) begin
                            game_mode  <= penalty_pkg::MODE_MULTI;
                            game_state <= penalty_pkg::ST_AIM;
                        end
                        // multi without a link stays in menu
                    end
                end
                penalty_pkg::ST_AIM: begin
                    if (left_clicked) game_state <= penalty_pkg::ST_SHOT;
                end
                penalty_pkg::ST_SHOT: begin
                    if (right_clicked) begin
                        game_state <= match_end ? penalty_pkg::ST_END : penalty_pkg::ST_AIM;
                    end
                end
                default: begin  // ST_END
                    if (right_clicked) game_state <= penalty_pkg::ST_MENU;
                end
            endcase
        end
    end

    // aim position frozen at the click
    always_ff @(posedge clk) begin
        if (take_shot) shot_xpos <= xpos;
    end

    shot_only_in_shot_state: assert property (
        @(posedge clk) disable iff (!arst_n)
        shot_fire |-> (game_state == penalty_pkg::ST_SHOT)
    ) else $error("shot_fire outside ST_SHOT");

endmodule

`default_nettype wire

//--- design/link_decoder.sv
`default_nettype none

`include "penalty_consts.svh"

module link_decoder (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    output logic       connected,
    output logic [1:0] remote_zone
);

    penalty_pkg::link_word rx_word;

    assign rx_word = rx_data;  // one byte read through two views

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            connected   <= 1'b0;
            remote_zone <= 2'd0;
        end else if (rx_valid) begin
            case (rx_word.hello.tag)
                `TAG_HELLO: begin
                    // wrong version drops the link
                    connected <= (rx_word.hello.version == `LINK_VERSION);
                end
                `TAG_KEEPER: begin
                    if (rx_word.keeper.zone != 2'd3) begin
                        remote_zone <= rx_word.keeper.zone;
                    end
                end
                default: begin
                    // junk bytes are dropped
                end
            endcase
        end
    end

    // zone 3 never reaches the judge
    remote_zone_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
        remote_zone != 2'd3
    ) else $error("remote_zone holds illegal zone 3");

endmodule

`default_nettype wire

//--- design/penalty_consts.svh
`ifndef PENALTY_CONSTS_SVH
`define PENALTY_CONSTS_SVH

// screen is split in three goal zones along x
`define ZONE_LEFT_END    213
`define ZONE_RIGHT_START 427

// match length and counter widths
`define MAX_ROUNDS 5
`define SCORE_W    3
`define POS_W      12

// link byte tags
`define TAG_KEEPER 2'b01
`define TAG_HELLO  2'b10

// protocol version both sides must agree on
`define LINK_VERSION 6'd3

`endif

//--- design/penalty_core.sv
`default_nettype none

`include "penalty_consts.svh"

module penalty_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  solo_enable,
    input  logic                  left_clicked,
    input  logic                  right_clicked,
    input  logic [`POS_W-1:0]     xpos,
    input  logic                  rx_valid,
    input  logic [7:0]            rx_data,
    output penalty_pkg::g_state   game_state,
    output penalty_pkg::g_mode    game_mode,
    output logic                  connected,
    output logic                  round_done,
    output logic                  is_scored,
    output logic [`SCORE_W-1:0]   score_player,
    output logic [`SCORE_W-1:0]   score_enemy,
    output logic                  match_end,
    output logic                  match_result
);

    logic [1:0]        remote_zone;
    logic              shot_fire;
    logic [`POS_W-1:0] shot_xpos;

    // decode
    link_decoder u_link_decoder (
        .clk, .arst_n, .rx_valid, .rx_data, .connected, .remote_zone
    );

    // execute
    game_state_sel u_game_state_sel (
        .clk, .arst_n, .left_clicked, .right_clicked, .solo_enable, .connected,
        .match_end, .xpos, .game_state, .game_mode, .shot_fire, .shot_xpos
    );

    shot_judge u_shot_judge (
        .clk, .arst_n, .shot_fire, .shot_xpos, .game_mode, .game_state,
        .remote_zone, .round_done, .is_scored
    );

    // result
    score_control u_score_control (
        .clk, .arst_n, .round_done, .is_scored, .game_state,
        .score_player, .score_enemy, .match_end, .match_result
    );

endmodule

`default_nettype wire

//--- design/penalty_pkg.sv
`default_nettype none

package penalty_pkg;

    // top level flow of one match
    typedef enum logic [1:0] {
        ST_MENU = 2'b00,
        ST_AIM  = 2'b01,
        ST_SHOT = 2'b10,
        ST_END  = 2'b11
    } g_state;

    typedef enum logic {
        MODE_SOLO  = 1'b0,  // keeper driven locally
        MODE_MULTI = 1'b1   // keeper driven by the opponent
    } g_mode;

    // keeper word, opponent tells where its keeper dives
    typedef struct packed {
        logic [1:0] tag;
        logic [1:0] zone;   // 0 left, 1 center, 2 right
        logic [3:0] spare;
    } link_keeper_t;

    // hello word, announces the protocol version
    typedef struct packed {
        logic [1:0] tag;
        logic [5:0] version;
    } link_hello_t;

    // one received byte, the tag picks the view
    typedef union packed {
        link_keeper_t keeper;
        link_hello_t  hello;
    } link_word;

endpackage

`default_nettype wire

//--- design/score_control.sv
`default_nettype none

`include "penalty_consts.svh"

module score_control (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  round_done,
    input  logic                  is_scored,
    input  penalty_pkg::g_state   game_state,
    output logic [`SCORE_W-1:0]   score_player,
    output logic [`SCORE_W-1:0]   score_enemy,
    output logic                  match_end,
    output logic                  match_result
);

    logic [`SCORE_W-1:0] round_cnt;
    logic [`SCORE_W-1:0] round_next;

    assign round_next = round_cnt + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            score_player <= '0;
            score_enemy  <= '0;
            round_cnt    <= '0;
            match_end    <= 1'b0;
        end else if (game_state == penalty_pkg::ST_MENU) begin
            // menu starts a fresh match
            score_player <= '0;
            score_enemy  <= '0;
            round_cnt    <= '0;
            match_end    <= 1'b0;
        end else if (round_done) begin
            if (is_scored) begin
                score_player <= score_player + 1'b1;
            end else begin
                score_enemy <= score_enemy + 1'b1;  // keeper saved
            end
            round_cnt <= round_next;
            if (round_next == `MAX_ROUNDS) match_end <= 1'b1;
        end
    end

    // ties go to the keeper side
    assign match_result = (score_player > score_enemy);

    // a shot after the last round would overrun the count
    score_sum_bounded: assert property (
        @(posedge clk) disable iff (!arst_n)
        (score_player + score_enemy) <= `MAX_ROUNDS
    ) else $error("score sum above MAX_ROUNDS");

endmodule

`default_nettype wire

//--- design/shot_judge.sv
`default_nettype none

`include "penalty_consts.svh"

module shot_judge (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                shot_fire,
    input  logic [`POS_W-1:0]   shot_xpos,
    input  penalty_pkg::g_mode  game_mode,
    input  penalty_pkg::g_state game_state,
    input  logic [1:0]          remote_zone,
    output logic                round_done,
    output logic                is_scored
);

    logic [1:0] shot_zone;
    logic [1:0] keeper_zone;
    logic [1:0] rot_idx;  // solo keeper, cycles 0..2

    always_comb begin
        if (shot_xpos < `ZONE_LEFT_END) begin
            shot_zone = 2'd0;
        end else if (shot_xpos >= `ZONE_RIGHT_START) begin
            shot_zone = 2'd2;
        end else begin
            shot_zone = 2'd1;
        end
    end

    assign keeper_zone = (game_mode == penalty_pkg::MODE_MULTI) ? remote_zone : rot_idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rot_idx <= 2'd0;
        end else if (game_state == penalty_pkg::ST_MENU) begin
            rot_idx <= 2'd0;  // every match starts at the left
        end else if (round_done) begin
            rot_idx <= (rot_idx == 2'd2) ? 2'd0 : rot_idx + 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            round_done <= 1'b0;
            is_scored  <= 1'b0;
        end else begin
            round_done <= shot_fire;
            if (shot_fire) is_scored <= (shot_zone != keeper_zone);  // wrong dive is a goal
        end
    end

    round_done_after_shot: assert property (
        @(posedge clk) disable iff (!arst_n)
        round_done == $past(shot_fire)
    ) else $error("round_done not one cycle after shot_fire");

endmodule

`default_nettype wire

//--- penalty_core.f
+incdir+design
design/penalty_pkg.sv
design/link_decoder.sv
design/game_state_sel.sv
design/shot_judge.sv
design/score_control.sv
design/penalty_core.sv
test/penalty_core_tb.sv

//--- test/penalty_core_tb.sv
`default_nettype none

`include "penalty_consts.svh"

module penalty_core_tb;

    localparam int RESET_CYCLES   = 10;
    localparam int RUN_CYCLES     = 6000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 12;  // room for reset and drain

    localparam logic [`POS_W-1:0] LEFT_EDGE  = `ZONE_LEFT_END;
    localparam logic [`POS_W-1:0] RIGHT_EDGE = `ZONE_RIGHT_START;

    logic                clk = 1'b0;
    logic                arst_n = 1'b0;
    logic                solo_enable = 1'b0;
    logic                left_clicked = 1'b0;
    logic                right_clicked = 1'b0;
    logic [`POS_W-1:0]   xpos = '0;
    logic                rx_valid = 1'b0;
    logic [7:0]          rx_data = 8'd0;
    penalty_pkg::g_state game_state;
    penalty_pkg::g_mode  game_mode;
    logic                connected;
    logic                round_done;
    logic                is_scored;
    logic [`SCORE_W-1:0] score_player;
    logic [`SCORE_W-1:0] score_enemy;
    logic                match_end;
    logic                match_result;

    // reference model
    penalty_pkg::g_state m_state;
    penalty_pkg::g_mode  m_mode;
    logic                m_shot_fire;
    logic [`POS_W-1:0]   m_shot_xpos;
    logic                m_connected;
    logic [1:0]          m_remote_zone;
    logic [1:0]          m_rot;
    logic                m_round_done;
    logic                m_is_scored;
    logic [`SCORE_W-1:0] m_score_p;
    logic [`SCORE_W-1:0] m_score_e;
    logic [`SCORE_W-1:0] m_rounds;
    logic                m_match_end;

    logic [15:0] lfsr = 16'd86;
    int          stim_cycles = 0;
    int          cycle_count = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          multi_shots = 0;
    int          refused_starts = 0;
    int          matches_ended = 0;

    penalty_core u_penalty_core (
        .clk, .arst_n, .solo_enable, .left_clicked, .right_clicked, .xpos, .rx_valid,
        .rx_data, .game_state, .game_mode, .connected, .round_done, .is_scored,
        .score_player, .score_enemy, .match_end, .match_result
    );

    always #2 clk = ~clk;  // period 4

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] bits;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            bits = {bits[14:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic [1:0] zone_of(input logic [`POS_W-1:0] x);
        if (x < LEFT_EDGE) return 2'd0;
        if (x >= RIGHT_EDGE) return 2'd2;
        return 2'd1;
    endfunction

    task automatic model_reset();
        m_state       = penalty_pkg::ST_MENU;
        m_mode        = penalty_pkg::MODE_SOLO;
        m_shot_fire   = 1'b0;
        m_shot_xpos   = '0;
        m_connected   = 1'b0;
        m_remote_zone = 2'd0;
        m_rot         = 2'd0;
        m_round_done  = 1'b0;
        m_is_scored   = 1'b0;
        m_score_p     = '0;
        m_score_e     = '0;
        m_rounds      = '0;
        m_match_end   = 1'b0;
    endtask

    // one clock edge of the game, all terms read before this edge
    task automatic model_step();
        penalty_pkg::g_state st;
        logic                done;
        logic                scored;
        logic                ended;
        logic                conn;
        logic [1:0]          keeper;
        st     = m_state;
        done   = m_round_done;
        scored = m_is_scored;
        ended  = m_match_end;
        conn   = m_connected;
        keeper = (m_mode == penalty_pkg::MODE_MULTI) ? m_remote_zone : m_rot;
        if (m_shot_fire) begin
            m_is_scored = (zone_of(m_shot_xpos) != keeper);  // goal unless keeper guessed
            if (m_mode == penalty_pkg::MODE_MULTI) multi_shots++;
        end
        m_round_done = m_shot_fire;
        if (st == penalty_pkg::ST_MENU) begin
            m_rot       = 2'd0;
            m_score_p   = '0;
            m_score_e   = '0;
            m_rounds    = '0;
            m_match_end = 1'b0;
        end else if (done) begin
            m_rot = (m_rot == 2'd2) ? 2'd0 : m_rot + 2'd1;
            if (scored) m_score_p = m_score_p + 1'b1;
            else m_score_e = m_score_e + 1'b1;
            m_rounds = m_rounds + 1'b1;
            if (m_rounds == `MAX_ROUNDS) m_match_end = 1'b1;
        end
        m_shot_fire = left_clicked && (st == penalty_pkg::ST_AIM);
        if (m_shot_fire) m_shot_xpos = xpos;
        case (st)
            penalty_pkg::ST_MENU: begin
                if (left_clicked && solo_enable) begin
                    m_mode  = penalty_pkg::MODE_SOLO;
                    m_state = penalty_pkg::ST_AIM;
                end else if (left_clicked && conn) begin
                    m_mode  = penalty_pkg::MODE_MULTI;
                    m_state = penalty_pkg::ST_AIM;
                end else if (left_clicked) begin
                    refused_starts++;  // multi asked for, no link
                end
            end
            penalty_pkg::ST_AIM: if (left_clicked) m_state = penalty_pkg::ST_SHOT;
            penalty_pkg::ST_SHOT: begin
                if (right_clicked) begin
                    m_state = ended ? penalty_pkg::ST_END : penalty_pkg::ST_AIM;
                    if (ended) matches_ended++;
                end
            end
            default: if (right_clicked) m_state = penalty_pkg::ST_MENU;
        endcase
        // link byte: tag in [7:6], version in [5:0], keeper zone in [5:4]
        if (rx_valid && rx_data[7:6] == `TAG_HELLO) m_connected = (rx_data[5:0] == `LINK_VERSION);
        if (rx_valid && rx_data[7:6] == `TAG_KEEPER && rx_data[5:4] != 2'd3) begin
            m_remote_zone = rx_data[5:4];
        end
    endtask

    task automatic drive_inputs();
        logic [15:0] r;
        logic [15:0] kind;
        logic        busy;
        // hold the right click until the shot has reached the scores
        busy = (m_state == penalty_pkg::ST_SHOT) && (m_shot_fire || m_round_done);
        r = rand_bits(2);
        left_clicked <= !left_clicked && (r[1:0] == 2'd0);
        r = rand_bits(2);
        right_clicked <= !right_clicked && !busy && (r[1:0] == 2'd0);
        r = rand_bits(12);
        case (r[11:9])
            3'd0: xpos <= r[8] ? LEFT_EDGE - 1'b1 : LEFT_EDGE;    // zone boundaries
            3'd1: xpos <= r[8] ? RIGHT_EDGE - 1'b1 : RIGHT_EDGE;
            default: xpos <= {2'b00, r[9:0] % 10'd640};
        endcase
        r = rand_bits(3);
        if (m_state == penalty_pkg::ST_MENU && r[2:0] == 3'd0) solo_enable <= !solo_enable;
        r = rand_bits(3);
        rx_valid <= (r[2:0] == 3'd0);
        kind = rand_bits(2);
        r = rand_bits(6);
        case (kind[1:0])
            2'd0: rx_data <= {`TAG_HELLO, `LINK_VERSION};
            2'd1: rx_data <= {`TAG_HELLO, r[5:0]};   // mostly a wrong version
            2'd2: rx_data <= {`TAG_KEEPER, r[5:0]};  // zone 3 now and then
            default: rx_data <= {r[0], r[0], r[5:0]};
        endcase
    endtask

    always @(posedge clk) begin
        if (!arst_n) model_reset();
        else model_step();
        if (arst_n && stim_cycles < RUN_CYCLES) begin
            drive_inputs();
            stim_cycles++;
        end else begin
            left_clicked  <= 1'b0;
            right_clicked <= 1'b0;
            rx_valid      <= 1'b0;
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        assert (game_state == m_state && game_mode == m_mode) else begin
            value_errors++;
            $display("error %0t: state %0d mode %0d, expected %0d %0d",
                     $time, game_state, game_mode, m_state, m_mode);
        end
        assert (connected == m_connected) else begin
            value_errors++;
            $display("error %0t: connected %b, expected %b", $time, connected, m_connected);
        end
        assert (round_done == m_round_done && is_scored == m_is_scored) else begin
            value_errors++;
            $display("error %0t: round_done %b is_scored %b, expected %b %b",
                     $time, round_done, is_scored, m_round_done, m_is_scored);
        end
        assert (score_player == m_score_p && score_enemy == m_score_e
                && match_end == m_match_end && match_result == (m_score_p > m_score_e)) else begin
            value_errors++;
            $display("error %0t: score %0d:%0d end %b result %b, expected %0d:%0d end %b",
                     $time, score_player, score_enemy, match_end, match_result,
                     m_score_p, m_score_e, m_match_end);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        wait (stim_cycles == RUN_CYCLES);
        repeat (4) @(posedge clk);  // let the last shot drain
        if (multi_shots == 0 || refused_starts == 0 || matches_ended == 0) begin
            other_errors++;
            $display("stimulus never reached a multi-mode shot, a refused start or a match end");
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
